/* verilog.f */
src/noc_pkg.sv
src/route_compute.sv
src/input_port.sv
src/output_arbiter.sv
src/spidergon_node.sv
src/spidergon_top.sv
dv/tb_spidergon.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module tb_spidergon

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module tb_spidergon -Mdir obj_dir
	out="$$(./obj_dir/Vtb_spidergon 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* dv/tb_spidergon.sv */
// directed testbench for the spidergon NoC, injects packets at the nodes and checks every ejection
`timescale 1ns/1ps

module tb_spidergon;

	localparam int num_nodes = 8;
	localparam int buffer_depth = 2;
	localparam int node_bits = $clog2(num_nodes);
	localparam int id_w = noc_pkg::node_id_width;
	localparam int data_w = noc_pkg::src_lsb;

	logic clk;
	logic reset;
	noc_pkg::link_t [num_nodes-1:0] inject;
	logic [num_nodes-1:0] inject_ready;
	noc_pkg::link_t [num_nodes-1:0] eject;
	logic [num_nodes-1:0] eject_ready;

	// expected flits, one queue per destination and source pair
	noc_pkg::flit_t exp_q [num_nodes*num_nodes][$];
	logic pkt_open [num_nodes];
	int cur_src [num_nodes];
	int last_arrival [num_nodes];
	int pending = 0;
	int flits_sent = 0;
	int cycles = 0;
	logic [15:0] lfsr_state = 16'd41;

	spidergon_top #(
		.num_nodes(num_nodes),
		.buffer_depth(buffer_depth)
	) u_spidergon_top (
		.clk(clk),
		.reset(reset),
		.inject(inject),
		.inject_ready(inject_ready),
		.eject(eject),
		.eject_ready(eject_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = 1'b1;
			#4 clk = 1'b0;
		end
	end

	// rising edges so far, so during a cycle the edge that ends it is cycles + 1
	always @(posedge clk)
		cycles <= cycles + 1;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	always @(posedge clk)
	begin
		if (cycles > 40 * flits_sent + 200)
			fail_now($sformatf("timeout: %0d cycles run, %0d flits never reached their eject port",
				cycles, pending));
	end

	task automatic compare_flit(input string name, input noc_pkg::flit_t got,
		input noc_pkg::flit_t want);
		if (got !== want)
			fail_now($sformatf("MISMATCH time %0t %s got %h expected %h", $time, name, got, want));
	endtask

	task automatic compare_kind(input string name, input noc_pkg::flit_kind_e got,
		input noc_pkg::flit_kind_e want);
		if (got !== want)
			fail_now($sformatf("MISMATCH time %0t %s got %s (%b) expected %s", $time, name,
				got.name(), got, want.name()));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic want);
		if (got !== want)
			fail_now($sformatf("MISMATCH time %0t %s got %b expected %b", $time, name, got, want));
	endtask

	task automatic compare_int(input string name, input int got, input int want);
		if (got != want)
			fail_now($sformatf("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, want));
	endtask

	// galois LFSR, one step per bit taken
	function automatic int rand_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
			value = (value << 1) | int'(lfsr_state[0]);
		end
		return value;
	endfunction

	// hops under across-first routing: short way round a quarter, else across then walk back
	function automatic int hop_count(input int src, input int dst);
		int rel;
		int half;
		int quarter;
		rel = (dst - src + num_nodes) % num_nodes;
		half = num_nodes / 2;
		quarter = num_nodes / 4;
		if (rel == 0)
			return 0;
		else if (rel <= quarter)
			return rel;
		else if (rel >= num_nodes - quarter)
			return num_nodes - rel;
		else if (rel >= half)
			return 1 + rel - half;
		else
			return 1 + half - rel;
	endfunction

	// every flit carries destination and source ids, the low byte is random
	function automatic noc_pkg::flit_t build_flit(input noc_pkg::flit_kind_e kind, input int src,
		input int dst);
		noc_pkg::flit_t f;
		f.kind = kind;
		f.payload[noc_pkg::dest_lsb +: id_w] = id_w'(dst);
		f.payload[noc_pkg::src_lsb +: id_w] = id_w'(src);
		f.payload[data_w-1:0] = data_w'(rand_bits(data_w));
		return f;
	endfunction

	task automatic check_eject(input int node, input noc_pkg::flit_t got);
		int src;
		int idx;
		noc_pkg::flit_t want;
		// body and tail belong to the packet already open at this port
		if (pkt_open[node])
			src = cur_src[node];
		else
			src = int'(got.payload[noc_pkg::src_lsb +: id_w]);
		idx = node * num_nodes + src;
		if (src >= num_nodes || exp_q[idx].size() == 0)
			fail_now($sformatf("unexpected flit %h came out of the eject port of node %0d", got, node));
		else
		begin
			want = exp_q[idx].pop_front();
			compare_kind($sformatf("eject[%0d].flit.kind", node), got.kind, want.kind);
			compare_flit($sformatf("eject[%0d].flit", node), got, want);
			if (got.kind == noc_pkg::kind_head)
			begin
				pkt_open[node] = 1'b1;
				cur_src[node] = src;
			end
			else if (got.kind == noc_pkg::kind_tail)
				pkt_open[node] = 1'b0;
			last_arrival[node] = cycles + 1;
			pending--;
		end
	endtask

	// outputs are settled at the falling edge, a transfer happens at the next rising edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			for (int n = 0; n < num_nodes; n++)
			begin
				if (eject[n].valid && eject_ready[n])
					check_eject(n, eject[n].flit);
			end
		end
	end

	task automatic send_flit(input int src, input int dst, input noc_pkg::flit_t f,
		output int accept_edge);
		exp_q[dst * num_nodes + src].push_back(f);
		pending++;
		inject[src].valid = 1'b1;
		inject[src].flit = f;
		@(negedge clk);
		while (!inject_ready[src])
			@(negedge clk);
		accept_edge = cycles + 1;
		@(posedge clk);
		#1;
		flits_sent++;
	endtask

	task automatic send_packet(input int src, input int dst, input int len);
		noc_pkg::flit_kind_e kind;
		int accept_edge;
		for (int i = 0; i < len; i++)
		begin
			if (len == 1)
				kind = noc_pkg::kind_single;
			else if (i == 0)
				kind = noc_pkg::kind_head;
			else if (i == len - 1)
				kind = noc_pkg::kind_tail;
			else
				kind = noc_pkg::kind_body;
			send_flit(src, dst, build_flit(kind, src, dst), accept_edge);
		end
		inject[src].valid = 1'b0;
	endtask

	task automatic send_burst(input int src, input int dst, input int count);
		for (int i = 0; i < count; i++)
			send_packet(src, dst, 1 + rand_bits(3));
	endtask

	task automatic wait_drain();
		while (pending != 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_ready_low(input int src);
		int waited;
		waited = 0;
		@(negedge clk);
		while (inject_ready[src] && waited < 100)
		begin
			@(negedge clk);
			waited++;
		end
		if (inject_ready[src])
			fail_now($sformatf("inject_ready of node %0d stayed high while its packet was blocked",
				src));
	endtask

	task automatic reset_state_check();
		@(negedge clk);
		for (int n = 0; n < num_nodes; n++)
		begin
			compare_bit($sformatf("eject[%0d].valid", n), eject[n].valid, 1'b0);
			compare_bit($sformatf("inject_ready[%0d]", n), inject_ready[n], 1'b1);
		end
		@(posedge clk);
		#1;
	endtask

	// one flit at a time through an idle network, so latency is exact
	task automatic all_pairs_single_flits();
		int k;
		for (int src = 0; src < num_nodes; src++)
		begin
			for (int dst = 0; dst < num_nodes; dst++)
			begin
				send_flit(src, dst, build_flit(noc_pkg::kind_single, src, dst), k);
				inject[src].valid = 1'b0;
				wait_drain();
				compare_int($sformatf("arrival cycle from %0d to %0d", src, dst),
					last_arrival[dst], k + 1 + hop_count(src, dst));
			end
		end
	endtask

	task automatic multi_flit_packets();
		int src;
		int dst;
		for (int i = 0; i < 8; i++)
		begin
			src = rand_bits(node_bits);
			dst = rand_bits(node_bits);
			send_packet(src, dst, 2 + rand_bits(3));
		end
		wait_drain();
	endtask

	// destination stalls, the packet backs up to the source
	task automatic back_pressure();
		eject_ready[5] = 1'b0;
		fork
			send_packet(1, 5, 24);
			begin
				wait_ready_low(1);
				compare_bit("eject[5].valid", eject[5].valid, 1'b1);
				repeat (10) @(posedge clk);
				#1;
				eject_ready[5] = 1'b1;
			end
		join
		wait_drain();
	endtask

	// three sources reach node 0 over its across and both ring inputs
	task automatic contention();
		fork
			send_burst(3, 0, 3);
			send_burst(4, 0, 3);
			send_burst(5, 0, 3);
		join
		wait_drain();
	endtask

	initial
	begin
		reset = 1'b1;
		inject = '0;
		eject_ready = '1;
		for (int n = 0; n < num_nodes; n++)
		begin
			pkt_open[n] = 1'b0;
			cur_src[n] = 0;
			last_arrival[n] = 0;
		end
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		reset_state_check();
		all_pairs_single_flits();
		multi_flit_packets();
		back_pressure();
		contention();

		// a few idle cycles so a stray flit would still be caught
		repeat (5) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

/* src/spidergon_top.sv */
// spidergon NoC top: builds the node ring with across links and exposes local inject and eject
`timescale 1ns/1ps

module spidergon_top #(
	parameter int num_nodes = 8,
	parameter int buffer_depth = 2
) (
	input  logic                            clk,
	input  logic                            reset,
	input  noc_pkg::link_t [num_nodes-1:0] inject,
	output logic [num_nodes-1:0]            inject_ready,
	output noc_pkg::link_t [num_nodes-1:0] eject,
	input  logic [num_nodes-1:0]            eject_ready
);

	noc_pkg::link_t [noc_pkg::num_ports-1:0] node_in [num_nodes];
	noc_pkg::link_t [noc_pkg::num_ports-1:0] node_out [num_nodes];
	logic [noc_pkg::num_ports-1:0] node_in_ready [num_nodes];
	logic [noc_pkg::num_ports-1:0] node_out_ready [num_nodes];

	for (genvar n = 0; n < num_nodes; n++)
	begin : g_node
		localparam int cw = (n + 1) % num_nodes;
		localparam int acw = (n + num_nodes - 1) % num_nodes;
		localparam int acr = (n + num_nodes / 2) % num_nodes;

		// ordered local, across, clockwise, anti-clockwise to match port_e
		assign node_in[n] = {
			inject[n],
			node_out[acr][noc_pkg::port_across],
			node_out[cw][noc_pkg::port_anti_clockwise],
			node_out[acw][noc_pkg::port_clockwise]
		};

		// ready comes back from whichever input the link lands on
		assign node_out_ready[n] = {
			eject_ready[n],
			node_in_ready[acr][noc_pkg::port_across],
			node_in_ready[cw][noc_pkg::port_anti_clockwise],
			node_in_ready[acw][noc_pkg::port_clockwise]
		};

		assign inject_ready[n] = node_in_ready[n][noc_pkg::port_local];
		assign eject[n] = node_out[n][noc_pkg::port_local];

		spidergon_node #(
			.num_nodes(num_nodes),
			.node_id(n),
			.buffer_depth(buffer_depth)
		) u_spidergon_node (
			.clk(clk),
			.reset(reset),
			.in_links(node_in[n]),
			.in_ready(node_in_ready[n]),
			.out_links(node_out[n]),
			.out_ready(node_out_ready[n])
		);
	end

endmodule

/* src/spidergon_node.sv */
// one spidergon router with four buffered inputs and four packet-locked outputs
`timescale 1ns/1ps

module spidergon_node #(
	parameter int num_nodes = 8,
	parameter int node_id = 0,
	parameter int buffer_depth = 2
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  noc_pkg::link_t [noc_pkg::num_ports-1:0] in_links,
	output logic [noc_pkg::num_ports-1:0]            in_ready,
	output noc_pkg::link_t [noc_pkg::num_ports-1:0] out_links,
	input  logic [noc_pkg::num_ports-1:0]            out_ready
);

	// buffer fronts of all inputs, seen by every arbiter
	noc_pkg::link_t [noc_pkg::num_ports-1:0] heads;
	noc_pkg::port_e want [noc_pkg::num_ports];

	// indexed [output][input]
	logic [noc_pkg::num_ports-1:0] req [noc_pkg::num_ports];
	logic [noc_pkg::num_ports-1:0] grant [noc_pkg::num_ports];

	logic [noc_pkg::num_ports-1:0] pop;

	for (genvar p = 0; p < noc_pkg::num_ports; p++)
	begin : g_input
		input_port #(
			.num_nodes(num_nodes),
			.node_id(node_id),
			.buffer_depth(buffer_depth)
		) u_input_port (
			.clk(clk),
			.reset(reset),
			.in_link(in_links[p]),
			.ready(in_ready[p]),
			.head_link(heads[p]),
			.want(want[p]),
			.pop(pop[p])
		);
	end

	// each input requests exactly the output its route names
	always_comb
	begin
		for (int o = 0; o < noc_pkg::num_ports; o++)
		begin
			for (int i = 0; i < noc_pkg::num_ports; i++)
				req[o][i] = heads[i].valid && (want[i] == noc_pkg::port_e'(o));
		end
	end

	// an input is served by at most one output per cycle
	always_comb
	begin
		pop = '0;
		for (int o = 0; o < noc_pkg::num_ports; o++)
			pop = pop | grant[o];
	end

	for (genvar o = 0; o < noc_pkg::num_ports; o++)
	begin : g_output
		output_arbiter u_output_arbiter (
			.clk(clk),
			.reset(reset),
			.req(req[o]),
			.heads(heads),
			.grant(grant[o]),
			.out_link(out_links[o]),
			.out_ready(out_ready[o])
		);
	end

endmodule

/* src/output_arbiter.sv */
// round-robin arbiter and mux for one router output, locked to an input for a whole packet
`timescale 1ns/1ps

module output_arbiter (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic [noc_pkg::num_ports-1:0]            req,
	input  noc_pkg::link_t [noc_pkg::num_ports-1:0] heads,
	output logic [noc_pkg::num_ports-1:0]            grant,
	output noc_pkg::link_t                           out_link,
	input  logic                                     out_ready
);

	logic locked;
	logic [1:0] owner;
	logic [1:0] last;
	logic [1:0] pick;
	logic [1:0] scan;
	logic [1:0] sel;
	logic found;
	logic fire;

	// search starts at the input after the previous winner
	always_comb
	begin
		found = 1'b0;
		pick = last;
		scan = last;
		for (int off = 1; off <= noc_pkg::num_ports; off++)
		begin
			scan = last + 2'(off);
			if (!found && req[scan] && heads[scan].valid &&
				noc_pkg::starts_packet(heads[scan].flit.kind))
			begin
				found = 1'b1;
				pick = scan;
			end
		end
	end

	always_comb
	begin
		sel = locked ? owner : pick;
		out_link.flit = heads[sel].flit;
		out_link.valid = locked ? (req[owner] && heads[owner].valid) : found;
		fire = out_link.valid && out_ready;
		grant = fire ? (4'b0001 << sel) : 4'b0000;
	end

	// a presented head holds the port even when stalled, so valid and flit stay stable
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			locked <= 1'b0;
			owner <= 2'd0;
			last <= 2'd3;
		end
		else if (out_link.valid)
		begin
			owner <= sel;
			locked <= !(fire && noc_pkg::ends_packet(out_link.flit.kind));
			if (!locked)
				last <= sel;
		end
	end

endmodule

/* src/input_port.sv */
// flit buffer for one router input link, also holds the packet route and drives ready
`timescale 1ns/1ps

module input_port #(
	parameter int num_nodes = 8,
	parameter int node_id = 0,
	parameter int buffer_depth = 2
) (
	input  logic           clk,
	input  logic           reset,
	input  noc_pkg::link_t in_link,
	output logic           ready,
	output noc_pkg::link_t head_link,
	output noc_pkg::port_e want,
	input  logic           pop
);

	localparam int ptr_width = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
	localparam int count_width = $clog2(buffer_depth + 1);
	localparam logic [ptr_width-1:0] last_slot = ptr_width'(buffer_depth - 1);
	localparam logic [count_width-1:0] full_count = count_width'(buffer_depth);

	noc_pkg::flit_t mem [buffer_depth];
	logic [ptr_width-1:0] rd_ptr;
	logic [ptr_width-1:0] wr_ptr;
	logic [count_width-1:0] count;
	logic push;
	logic take;
	noc_pkg::port_e decoded_port;
	noc_pkg::port_e held_port;

	function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
		return (ptr == last_slot) ? '0 : ptr + 1'b1;
	endfunction

	// on/off flow control, only registered occupancy is looked at
	assign ready = (count != full_count);
	assign push = in_link.valid && ready;
	assign take = pop && head_link.valid;

	assign head_link.valid = (count != '0);
	assign head_link.flit = mem[rd_ptr];

	route_compute #(
		.num_nodes(num_nodes),
		.node_id(node_id)
	) u_route_compute (
		.head(head_link.flit),
		.out_port(decoded_port)
	);

	// head decides the route, the rest of the packet follows the held one
	assign want = noc_pkg::starts_packet(head_link.flit.kind) ? decoded_port : held_port;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_link.flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			held_port <= noc_pkg::port_local;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (take)
				rd_ptr <= next_ptr(rd_ptr);

			case ({push, take})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			if (take && noc_pkg::starts_packet(head_link.flit.kind))
				held_port <= decoded_port;
		end
	end

endmodule

/* src/route_compute.sv */
// across-first spidergon routing decision for a head flit at one node
`timescale 1ns/1ps

module route_compute #(
	parameter int num_nodes = 8,
	parameter int node_id = 0
) (
	input  noc_pkg::flit_t head,
	output noc_pkg::port_e out_port
);

	// two extra bits so dest + num_nodes - node_id never overflows
	localparam int rel_width = noc_pkg::node_id_width + 2;
	localparam logic [rel_width-1:0] nodes_w = rel_width'(num_nodes);
	localparam logic [rel_width-1:0] quarter_w = rel_width'(num_nodes / 4);
	localparam logic [rel_width-1:0] offset_w = rel_width'(num_nodes - node_id);

	logic [noc_pkg::node_id_width-1:0] dest;
	logic [rel_width-1:0] diff;
	logic [rel_width-1:0] rel;

	always_comb
	begin
		dest = head.payload[noc_pkg::dest_lsb +: noc_pkg::node_id_width];
		diff = rel_width'(dest) + offset_w;

		// distance going clockwise, modulo the ring size
		rel = (diff >= nodes_w) ? diff - nodes_w : diff;

		if (rel == '0)
			out_port = noc_pkg::port_local;
		else if (rel <= quarter_w)
			out_port = noc_pkg::port_clockwise;
		else if (rel >= nodes_w - quarter_w)
			out_port = noc_pkg::port_anti_clockwise;
		else
			// far side of the ring, cross once and then walk at most a quarter
			out_port = noc_pkg::port_across;
	end

endmodule

/* src/noc_pkg.sv */
// shared flit, link and port types for the spidergon NoC routers and their testbench
package noc_pkg;

	// payload bits carried by every flit
	localparam int flit_data_width = 16;

	// node address width, enough for up to 16 nodes
	localparam int node_id_width = 4;

	// where the address fields sit inside a head or single flit payload
	localparam int dest_lsb = flit_data_width - node_id_width;
	localparam int src_lsb = dest_lsb - node_id_width;

	// number of router ports, three links plus local
	localparam int num_ports = 4;

	typedef enum logic [1:0] {
		kind_tail   = 2'b00,
		kind_head   = 2'b01,
		kind_body   = 2'b10,
		kind_single = 2'b11
	} flit_kind_e;

	typedef struct packed {
		flit_kind_e                 kind;
		logic [flit_data_width-1:0] payload;
	} flit_t;

	// what a sender drives onto one link in one cycle
	typedef struct packed {
		logic  valid;
		flit_t flit;
	} link_t;

	typedef enum logic [1:0] {
		port_anti_clockwise = 2'd0,
		port_clockwise      = 2'd1,
		port_across         = 2'd2,
		port_local          = 2'd3
	} port_e;

	// head and single flits open a packet
	function automatic logic starts_packet(input flit_kind_e kind);
		return (kind == kind_head) || (kind == kind_single);
	endfunction

	// tail and single flits close a packet and free the output port
	function automatic logic ends_packet(input flit_kind_e kind);
		return (kind == kind_tail) || (kind == kind_single);
	endfunction

endpackage
